// ==== Bender.yml ====
package:
  name: gtp_lane

sources:
  - verilog/gtp_lane_pkg.sv
  - verilog/lane_data_if.sv
  - verilog/phase_align_timer.sv
  - verilog/prim_classifier.sv
  - verilog/lane_reset_sequencer.sv
  - verilog/lane_datapath.sv
  - verilog/lane_debug_monitor.sv
  - verilog/gtp_lane_top.sv
  - target: test
    files:
      - tests/tb_gtp_lane_top.sv

// ==== filelist.f ====
verilog/gtp_lane_pkg.sv
verilog/lane_data_if.sv
verilog/phase_align_timer.sv
verilog/prim_classifier.sv
verilog/lane_reset_sequencer.sv
verilog/lane_datapath.sv
verilog/lane_debug_monitor.sv
verilog/gtp_lane_top.sv
tests/tb_gtp_lane_top.sv

// ==== tests/tb_gtp_lane_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gtp_lane_top;

   localparam int PHASE_ALIGN_EDGES   = 3;
   localparam int ALIGN_CYCLES_EXP    = 32;
   localparam int SETPHASE_CYCLES_EXP = 32;
   localparam int TIMEOUT_CYCLES      = 200;

   logic         txusrclk20;
   logic         resetdone0;
   logic         plllkdet;
   logic         dcm_locked;
   logic [31:0]  txdata_fis;
   logic         tx_charisk_fis;
   logic [31:0]  rxdata;
   logic [3:0]   rxcharisk;
   logic [31:0]  gtx_tune;
   logic [31:0]  phy2cs_data;
   logic         phy2cs_k;

   logic         gtpreset;
   logic         phase_align;
   logic         set_phase;
   logic         sync_done;
   logic [31:0]  txdata_gt;
   logic [3:0]   txcharisk_gt;
   logic [31:0]  rxdata_fis;
   logic [3:0]   rxcharisk_fis;
   logic [31:0]  cap_txdata;
   logic [3:0]   cap_txdatak;
   logic [31:0]  cap_rxdata;
   logic [3:0]   cap_rxdatak;
   logic [2:0]   loopback;
   logic [2:0]   txdiffctrl;
   logic [2:0]   txpreemph;
   logic [1:0]   rxeqmix;
   logic [127:0] dbg_word;

   int           value_errors;
   int           timeout_errors;
   integer       seed;
   logic [1:0]   lock_sel;
   bit           expect_synced;
   logic [31:0]  exp_tx;
   logic [3:0]   exp_txk;
   logic [31:0]  prev_tx;
   logic [3:0]   prev_txk;
   logic [31:0]  prev_rx;
   logic [3:0]   prev_rxk;
   logic [31:0]  prim_table [12];
   int           i;

   gtp_lane_top u_gtp_lane_top (
      .tile0_txusrclk20_i        (txusrclk20),
      .tile0_resetdone0_i        (resetdone0),
      .plllkdet_i                (plllkdet),
      .dcm_locked_i              (dcm_locked),
      .txdata_fis_i              (txdata_fis),
      .tx_charisk_fis_i          (tx_charisk_fis),
      .tile0_rxdata_i            (rxdata),
      .tile0_rxcharisk_i         (rxcharisk),
      .gtx_tune_i                (gtx_tune),
      .phy2cs_data_i             (phy2cs_data),
      .phy2cs_k_i                (phy2cs_k),
      .tile0_gtpreset_o          (gtpreset),
      .tile0_txenpmaphasealign_o (phase_align),
      .tile0_txpmasetphase_o     (set_phase),
      .tx_sync_done_o            (sync_done),
      .tile0_txdata_o            (txdata_gt),
      .tile0_txcharisk_o         (txcharisk_gt),
      .rxdata_fis_o              (rxdata_fis),
      .rxcharisk_o               (rxcharisk_fis),
      .gtx_txdata_o              (cap_txdata),
      .gtx_txdatak_o             (cap_txdatak),
      .gtx_rxdata_o              (cap_rxdata),
      .gtx_rxdatak_o             (cap_rxdatak),
      .tile0_loopback_o          (loopback),
      .tile0_txdiffctrl_o        (txdiffctrl),
      .tile0_txpreemphasis_o     (txpreemph),
      .tile0_rxeqmix_o           (rxeqmix),
      .oob2dbg_o                 (dbg_word)
   );

   always #2 txusrclk20 = ~txusrclk20;

   task automatic expect_true(input bit cond, input string what);
      assert (cond)
      else
      begin
         value_errors++;
         $display("FAILED at %0t: %s", $time, what);
      end
   endtask

   task automatic compare_word(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         value_errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // SATA primitive code, 1 to 12 in table order
   function automatic logic [7:0] prim_code_of(input logic [31:0] w);
      logic [7:0] code;
      code = 8'd0;
      for (int n = 0; n < 12; n++)
      begin
         if (prim_table[n] == w)
         begin
            code = 8'(n + 1);
         end
      end
      return code;
   endfunction

   // Mix of primitives and plain random data
   task automatic pick_word(output logic [31:0] w);
      integer sel;
      sel = $unsigned($random(seed)) % 16;
      if (sel < 12)
      begin
         w = prim_table[sel];
      end
      else
      begin
         w = $random(seed);
      end
   endtask

   task automatic drive_inputs();
      logic [31:0] rnd;
      rnd = $random(seed);
      pick_word(txdata_fis);
      pick_word(rxdata);
      tx_charisk_fis = rnd[0];
      rxcharisk      = rnd[4:1];
      phy2cs_k       = rnd[5];
      gtx_tune       = $random(seed);
      phy2cs_data    = $random(seed);
      plllkdet       = lock_sel[1];
      dcm_locked     = lock_sel[0];
   endtask

   task automatic check_outputs();
      logic [127:0] exp_dbg;
      if (sync_done)
      begin
         exp_tx  = txdata_fis;
         exp_txk = {3'b000, tx_charisk_fis};
      end
      else
      begin
         exp_tx  = 32'h7B4A_4ABC;
         exp_txk = 4'b0001;
      end
      compare_word("TX data", txdata_gt, exp_tx);
      compare_word("TX K flags", txcharisk_gt, exp_txk);
      compare_word("transceiver reset", gtpreset, !(plllkdet && dcm_locked));
      compare_word("RX data pass-through", rxdata_fis, rxdata);
      compare_word("RX K pass-through", rxcharisk_fis, rxcharisk);
      compare_word("loopback field", loopback, gtx_tune[2:0]);
      compare_word("diff swing field", txdiffctrl, gtx_tune[5:3]);
      compare_word("pre-emphasis field", txpreemph, gtx_tune[8:6]);
      compare_word("equalizer field", rxeqmix, gtx_tune[17:16]);
      exp_dbg = {7'b0000000, phy2cs_k, phy2cs_data, prim_code_of(rxdata),
                 prim_code_of(exp_tx), rxcharisk, exp_txk, rxdata, exp_tx};
      compare_word("debug word", dbg_word, exp_dbg);
      compare_word("debug spare bits", dbg_word[127:121], 7'd0);
   endtask

   task automatic check_reset_state();
      expect_true(!phase_align && !set_phase && !sync_done, "sequencer outputs high in reset");
      compare_word("captured TX data in reset", cap_txdata, 32'd0);
      compare_word("captured TX K in reset", cap_txdatak, 4'd0);
      compare_word("captured RX data in reset", cap_rxdata, 32'd0);
      compare_word("captured RX K in reset", cap_rxdatak, 4'd0);
   endtask

   task automatic record_words();
      prev_tx  = exp_tx;
      prev_txk = exp_txk;
      prev_rx  = rxdata;
      prev_rxk = rxcharisk;
   endtask

   // One clock, then new stimulus on the falling edge
   task automatic advance_cycle();
      @(posedge txusrclk20);
      @(negedge txusrclk20);
      compare_word("captured TX data", cap_txdata, prev_tx);
      compare_word("captured TX K", cap_txdatak, prev_txk);
      compare_word("captured RX data", cap_rxdata, prev_rx);
      compare_word("captured RX K", cap_rxdatak, prev_rxk);
      if (expect_synced)
      begin
         expect_true(phase_align && sync_done && !set_phase, "synced state not held");
      end
      drive_inputs();
      #1;
      check_outputs();
      record_words();
   endtask

   task automatic wait_phase_align();
      int edges;
      edges = 0;
      while (!phase_align && edges < TIMEOUT_CYCLES)
      begin
         advance_cycle();
         edges++;
      end
      if (!phase_align)
      begin
         timeout_errors++;
         $display("Timed out waiting for phase-align to rise after reset release");
      end
      else
      begin
         expect_true(edges <= PHASE_ALIGN_EDGES, "phase-align rose too late after reset");
         expect_true(!set_phase && !sync_done, "set-phase or sync-done high at align start");
      end
   endtask

   task automatic count_align_cycles();
      int cycles;
      cycles = 0;
      while (phase_align && !set_phase && cycles < TIMEOUT_CYCLES)
      begin
         expect_true(!sync_done, "sync-done high during align");
         advance_cycle();
         cycles++;
      end
      if (cycles >= TIMEOUT_CYCLES)
      begin
         timeout_errors++;
         $display("Timed out waiting for set-phase to rise");
      end
      else
      begin
         compare_word("align cycles", cycles, ALIGN_CYCLES_EXP);
         expect_true(phase_align && set_phase, "set-phase did not follow align");
      end
   endtask

   task automatic count_setphase_cycles();
      int cycles;
      cycles = 0;
      while (set_phase && cycles < TIMEOUT_CYCLES)
      begin
         expect_true(phase_align && !sync_done, "bad outputs during set-phase");
         advance_cycle();
         cycles++;
      end
      if (cycles >= TIMEOUT_CYCLES)
      begin
         timeout_errors++;
         $display("Timed out waiting for set-phase to fall");
      end
      else
      begin
         compare_word("set-phase cycles", cycles, SETPHASE_CYCLES_EXP);
         expect_true(sync_done && phase_align, "sync-done not raised as set-phase fell");
         expect_synced = 1'b1;
      end
   endtask

   initial
   begin
      prim_table[0]  = 32'h7B4A_4ABC;
      prim_table[1]  = 32'hB5B5_957C;
      prim_table[2]  = 32'h4A4A_957C;
      prim_table[3]  = 32'h5757_B57C;
      prim_table[4]  = 32'h3737_B57C;
      prim_table[5]  = 32'hD5D5_B57C;
      prim_table[6]  = 32'hD5D5_AA7C;
      prim_table[7]  = 32'h3535_B57C;
      prim_table[8]  = 32'h5656_B57C;
      prim_table[9]  = 32'h5858_B57C;
      prim_table[10] = 32'h9999_AA7C;
      prim_table[11] = 32'h5555_B57C;
      seed           = 32'hed6517c9;
      value_errors   = 0;
      timeout_errors = 0;
      expect_synced  = 1'b0;
      lock_sel       = 2'b11;
      txusrclk20     = 1'b0;
      resetdone0     = 1'b0;
      drive_inputs();
      repeat (3)
      begin
         @(negedge txusrclk20);
         check_reset_state();
      end
      resetdone0 = 1'b1;
      drive_inputs();
      #1;
      check_reset_state();
      check_outputs();
      record_words();
      wait_phase_align();
      if (timeout_errors == 0)
      begin
         count_align_cycles();
      end
      if (timeout_errors == 0)
      begin
         count_setphase_cycles();
      end
      if (timeout_errors == 0)
      begin
         repeat (200) advance_cycle();
         // Walk all lock combinations for the transceiver reset
         for (i = 0; i < 4; i++)
         begin
            lock_sel = i[1:0];
            repeat (2) advance_cycle();
         end
      end
      $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/gtp_lane_pkg.sv ====
`default_nettype none

package gtp_lane_pkg;

   // Word types seen at the transceiver boundary
   typedef logic [31:0]  dword_t;
   typedef logic [3:0]   charisk_t;
   typedef logic [7:0]   prim_code_t;

   // Tune word fields
   typedef logic [2:0]   loopback_t;
   typedef logic [2:0]   drive_t;
   typedef logic [1:0]   rxeq_t;

   typedef logic [127:0] dbg_word_t;
   typedef logic [15:0]  timer_count_t;

   localparam int SYNC_STAGES          = 2;
   localparam int ALIGN_BASE_CYCLES    = 32;
   localparam int SETPHASE_BASE_CYCLES = 16;

   // SATA primitives, K28.5 or K28.3 in byte 0
   localparam dword_t PRIM_ALIGN = 32'h7B4A_4ABC;
   localparam dword_t PRIM_SYNC  = 32'hB5B5_957C;
   localparam dword_t PRIM_R_RDY = 32'h4A4A_957C;
   localparam dword_t PRIM_X_RDY = 32'h5757_B57C;
   localparam dword_t PRIM_SOF   = 32'h3737_B57C;
   localparam dword_t PRIM_EOF   = 32'hD5D5_B57C;
   localparam dword_t PRIM_HOLD  = 32'hD5D5_AA7C;
   localparam dword_t PRIM_R_OK  = 32'h3535_B57C;
   localparam dword_t PRIM_R_ERR = 32'h5656_B57C;
   localparam dword_t PRIM_WTRM  = 32'h5858_B57C;
   localparam dword_t PRIM_CONT  = 32'h9999_AA7C;
   localparam dword_t PRIM_R_IP  = 32'h5555_B57C;

   localparam charisk_t K_BYTE0 = 4'b0001;

   // Low bit of each field in the tune word
   localparam int TUNE_LOOPBACK_LSB = 0;
   localparam int TUNE_TXDIFF_LSB   = 3;
   localparam int TUNE_PREEMPH_LSB  = 6;
   localparam int TUNE_RXEQ_LSB     = 16;

   typedef enum logic [1:0] {
      WAIT_RESET,
      ALIGN,
      SET_PHASE,
      SYNCED
   } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/gtp_lane_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gtp_lane_top #(
   parameter int PLL_DIVSEL_OUT = 2
) (
   input  wire                          tile0_txusrclk20_i,
   input  wire                          tile0_resetdone0_i,
   input  wire                          plllkdet_i,
   input  wire                          dcm_locked_i,
   input  wire gtp_lane_pkg::dword_t    txdata_fis_i,
   input  wire                          tx_charisk_fis_i,
   input  wire gtp_lane_pkg::dword_t    tile0_rxdata_i,
   input  wire gtp_lane_pkg::charisk_t  tile0_rxcharisk_i,
   input  wire gtp_lane_pkg::dword_t    gtx_tune_i,
   input  wire gtp_lane_pkg::dword_t    phy2cs_data_i,
   input  wire                          phy2cs_k_i,
   output logic                         tile0_gtpreset_o,
   output logic                         tile0_txenpmaphasealign_o,
   output logic                         tile0_txpmasetphase_o,
   output logic                         tx_sync_done_o,
   output gtp_lane_pkg::dword_t         tile0_txdata_o,
   output gtp_lane_pkg::charisk_t       tile0_txcharisk_o,
   output gtp_lane_pkg::dword_t         rxdata_fis_o,
   output gtp_lane_pkg::charisk_t       rxcharisk_o,
   output gtp_lane_pkg::dword_t         gtx_txdata_o,
   output gtp_lane_pkg::charisk_t       gtx_txdatak_o,
   output gtp_lane_pkg::dword_t         gtx_rxdata_o,
   output gtp_lane_pkg::charisk_t       gtx_rxdatak_o,
   output gtp_lane_pkg::loopback_t      tile0_loopback_o,
   output gtp_lane_pkg::drive_t         tile0_txdiffctrl_o,
   output gtp_lane_pkg::drive_t         tile0_txpreemphasis_o,
   output gtp_lane_pkg::rxeq_t          tile0_rxeqmix_o,
   output gtp_lane_pkg::dbg_word_t      oob2dbg_o
);

   import gtp_lane_pkg::*;

   logic sync_done;

   lane_data_if u_lane_if ();

   lane_reset_sequencer #(
      .PLL_DIVSEL_OUT (PLL_DIVSEL_OUT)
   ) u_lane_reset_sequencer (
      .tile0_txusrclk20_i  (tile0_txusrclk20_i),
      .tile0_resetdone0_i  (tile0_resetdone0_i),
      .plllkdet_i          (plllkdet_i),
      .dcm_locked_i        (dcm_locked_i),
      .gtp_reset_o         (tile0_gtpreset_o),
      .txenpmaphasealign_o (tile0_txenpmaphasealign_o),
      .txpmasetphase_o     (tile0_txpmasetphase_o),
      .sync_done_o         (sync_done)
   );

   assign tx_sync_done_o = sync_done;

   lane_datapath u_lane_datapath (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .sync_done_i        (sync_done),
      .txdata_ll_i        (txdata_fis_i),
      .txdatak_ll_i       (tx_charisk_fis_i),
      .rxdata_i           (tile0_rxdata_i),
      .rxcharisk_i        (tile0_rxcharisk_i),
      .lane               (u_lane_if.source),
      .gtx_txdata_o       (gtx_txdata_o),
      .gtx_rxdata_o       (gtx_rxdata_o),
      .gtx_txdatak_o      (gtx_txdatak_o),
      .gtx_rxdatak_o      (gtx_rxdatak_o)
   );

   lane_debug_monitor u_lane_debug_monitor (
      .lane          (u_lane_if.monitor),
      .phy2cs_data_i (phy2cs_data_i),
      .phy2cs_k_i    (phy2cs_k_i),
      .oob2dbg_o     (oob2dbg_o)
   );

   // Transceiver TX words straight from the select
   assign tile0_txdata_o    = u_lane_if.tx_data;
   assign tile0_txcharisk_o = u_lane_if.tx_charisk;

   // RX goes to the link layer untouched
   assign rxdata_fis_o = tile0_rxdata_i;
   assign rxcharisk_o  = tile0_rxcharisk_i;

   // Analog settings taken from the tune word
   assign tile0_loopback_o      = gtx_tune_i[TUNE_LOOPBACK_LSB +: $bits(loopback_t)];
   assign tile0_txdiffctrl_o    = gtx_tune_i[TUNE_TXDIFF_LSB +: $bits(drive_t)];
   assign tile0_txpreemphasis_o = gtx_tune_i[TUNE_PREEMPH_LSB +: $bits(drive_t)];
   assign tile0_rxeqmix_o       = gtx_tune_i[TUNE_RXEQ_LSB +: $bits(rxeq_t)];

endmodule

`default_nettype wire

// ==== verilog/lane_data_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface lane_data_if;

   import gtp_lane_pkg::*;

   // Words exchanged with the transceiver, no handshake
   dword_t   tx_data;
   charisk_t tx_charisk;
   dword_t   rx_data;
   charisk_t rx_charisk;

   modport source (
      output tx_data, tx_charisk, rx_data, rx_charisk
   );

   modport monitor (
      input tx_data, tx_charisk, rx_data, rx_charisk
   );

endinterface

`default_nettype wire

// ==== verilog/lane_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module lane_datapath (
   input  wire                    tile0_txusrclk20_i,
   input  wire                    tile0_resetdone0_i,
   input  wire                    sync_done_i,
   input  wire gtp_lane_pkg::dword_t   txdata_ll_i,
   input  wire                    txdatak_ll_i,
   input  wire gtp_lane_pkg::dword_t   rxdata_i,
   input  wire gtp_lane_pkg::charisk_t rxcharisk_i,
   lane_data_if.source            lane,
   output gtp_lane_pkg::dword_t   gtx_txdata_o,
   output gtp_lane_pkg::dword_t   gtx_rxdata_o,
   output gtp_lane_pkg::charisk_t gtx_txdatak_o,
   output gtp_lane_pkg::charisk_t gtx_rxdatak_o
);

   import gtp_lane_pkg::*;

   dword_t   tx_word;
   charisk_t tx_k;

   // Link stays quiet with ALIGN until the TX phase is settled
   assign tx_word = sync_done_i ? txdata_ll_i : PRIM_ALIGN;
   // The link layer only ever marks byte 0 as a control character
   assign tx_k    = sync_done_i ? (K_BYTE0 & {4{txdatak_ll_i}}) : K_BYTE0;

   assign lane.tx_data    = tx_word;
   assign lane.tx_charisk = tx_k;
   assign lane.rx_data    = rxdata_i;
   assign lane.rx_charisk = rxcharisk_i;

   // Monitor copies of both directions
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         gtx_txdata_o  <= '0;
         gtx_txdatak_o <= '0;
         gtx_rxdata_o  <= '0;
         gtx_rxdatak_o <= '0;
      end
      else
      begin
         gtx_txdata_o  <= tx_word;
         gtx_txdatak_o <= tx_k;
         gtx_rxdata_o  <= rxdata_i;
         gtx_rxdatak_o <= rxcharisk_i;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/lane_debug_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module lane_debug_monitor (
   lane_data_if.monitor             lane,
   input  wire gtp_lane_pkg::dword_t phy2cs_data_i,
   input  wire                      phy2cs_k_i,
   output gtp_lane_pkg::dbg_word_t  oob2dbg_o
);

   import gtp_lane_pkg::*;

   prim_code_t tx_code;
   prim_code_t rx_code;

   prim_classifier u_tx_classifier (
      .dword_i (lane.tx_data),
      .code_o  (tx_code)
   );

   prim_classifier u_rx_classifier (
      .dword_i (lane.rx_data),
      .code_o  (rx_code)
   );

   // Top seven bits are spare
   assign oob2dbg_o = {
      7'b0000000,
      phy2cs_k_i,
      phy2cs_data_i,
      rx_code,
      tx_code,
      lane.rx_charisk,
      lane.tx_charisk,
      lane.rx_data,
      lane.tx_data
   };

endmodule

`default_nettype wire

// ==== verilog/lane_reset_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lane_reset_sequencer #(
   parameter int PLL_DIVSEL_OUT = 2
) (
   input  wire  tile0_txusrclk20_i,
   input  wire  tile0_resetdone0_i,
   input  wire  plllkdet_i,
   input  wire  dcm_locked_i,
   output logic gtp_reset_o,
   output logic txenpmaphasealign_o,
   output logic txpmasetphase_o,
   output logic sync_done_o
);

   import gtp_lane_pkg::*;

   localparam timer_count_t ALIGN_CYCLES    = timer_count_t'(ALIGN_BASE_CYCLES);
   localparam timer_count_t SETPHASE_CYCLES =
      timer_count_t'(SETPHASE_BASE_CYCLES * PLL_DIVSEL_OUT);

   logic [SYNC_STAGES-1:0] done_sync_q;
   logic                   resetdone_sync;
   seq_state_t             state_q;
   seq_state_t             state_d;
   logic                   timer_start;
   timer_count_t           timer_load;
   logic                   timer_expire;

   // Transceiver stays in reset until both clocks are locked
   assign gtp_reset_o = !(plllkdet_i && dcm_locked_i);

   // Reset-done comes from the transceiver clock domain
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         done_sync_q <= '0;
      end
      else
      begin
         done_sync_q <= {done_sync_q[SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign resetdone_sync = done_sync_q[SYNC_STAGES-1];

   always_comb
   begin
      state_d     = state_q;
      timer_start = 1'b0;
      timer_load  = ALIGN_CYCLES;
      case (state_q)
         WAIT_RESET:
         begin
            if (resetdone_sync)
            begin
               timer_start = 1'b1;
               state_d     = ALIGN;
            end
         end
         ALIGN:
         begin
            // Set-phase length depends on the PLL output divider
            if (timer_expire)
            begin
               timer_start = 1'b1;
               timer_load  = SETPHASE_CYCLES;
               state_d     = SET_PHASE;
            end
         end
         SET_PHASE:
         begin
            if (timer_expire)
            begin
               state_d = SYNCED;
            end
         end
         default:
         begin
            state_d = SYNCED;
         end
      endcase
   end

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         state_q <= WAIT_RESET;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   phase_align_timer u_phase_align_timer (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .start_i            (timer_start),
      .load_count_i       (timer_load),
      .expire_o           (timer_expire)
   );

   // Phase-align stays on once the sequence has started
   assign txenpmaphasealign_o = (state_q != WAIT_RESET);
   assign txpmasetphase_o     = (state_q == SET_PHASE);
   assign sync_done_o         = (state_q == SYNCED);

endmodule

`default_nettype wire

// ==== verilog/phase_align_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_align_timer (
   input  wire                        tile0_txusrclk20_i,
   input  wire                        tile0_resetdone0_i,
   input  wire                        start_i,
   input  wire gtp_lane_pkg::timer_count_t load_count_i,
   output logic                       expire_o
);

   import gtp_lane_pkg::*;

   timer_count_t count_q;

   // A start reloads the counter even while it is running
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         count_q <= '0;
      end
      else if (start_i)
      begin
         count_q <= load_count_i;
      end
      else if (count_q != '0)
      begin
         count_q <= count_q - timer_count_t'(1);
      end
   end

   // High in the cycle whose closing edge takes the count to zero,
   // so the strobe lands exactly load_count cycles after start
   assign expire_o = (count_q == timer_count_t'(1));

endmodule

`default_nettype wire

// ==== verilog/prim_classifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module prim_classifier (
   input  wire gtp_lane_pkg::dword_t    dword_i,
   output gtp_lane_pkg::prim_code_t code_o
);

   import gtp_lane_pkg::*;

   // Codes follow the order of the primitive table, 0 for data
   always_comb
   begin
      case (dword_i)
         PRIM_ALIGN: code_o = prim_code_t'(1);
         PRIM_SYNC:  code_o = prim_code_t'(2);
         PRIM_R_RDY: code_o = prim_code_t'(3);
         PRIM_X_RDY: code_o = prim_code_t'(4);
         PRIM_SOF:   code_o = prim_code_t'(5);
         PRIM_EOF:   code_o = prim_code_t'(6);
         PRIM_HOLD:  code_o = prim_code_t'(7);
         PRIM_R_OK:  code_o = prim_code_t'(8);
         PRIM_R_ERR: code_o = prim_code_t'(9);
         PRIM_WTRM:  code_o = prim_code_t'(10);
         PRIM_CONT:  code_o = prim_code_t'(11);
         PRIM_R_IP:  code_o = prim_code_t'(12);
         default:    code_o = '0;
      endcase
   end

endmodule

`default_nettype wire
